// File: hw/mem_map_macros.svh
`ifndef MEM_MAP_MACROS_SVH
`define MEM_MAP_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Memory map dimensions
////////////////////////////////////////////////////////////////////////////

// One data word
`define MEM_DATA_W 16

// Byte address seen by the host
`define MEM_ADDR_W 16

// Word index inside one bank, addr[10:1]
`define MEM_WORD_IDX_W 10

// Bank index, addr[15:11]
`define MEM_BANK_IDX_W 5

// Banks actually fitted, 0000..B7FF
`define MEM_NUM_BANKS 23

// Byte lanes per word, sel[0] low byte and sel[1] high byte
`define MEM_LANES 2

// Read value for any address outside the map
`define MEM_FILL_WORD 16'hFFFF

`endif

// File: hw/mem_map_pkg.sv
`include "mem_map_macros.svh"

package mem_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data and address types
  ////////////////////////////////////////////////////////////////////////////

  // One memory word
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;

  // Byte address split the way the banks decode it
  // Bank select on top, then the word inside the bank
  typedef struct packed {
    logic [`MEM_BANK_IDX_W-1:0] bank;
    logic [`MEM_WORD_IDX_W-1:0] word;
    // Odd byte of a word, the memory ignores it
    logic                       byte_sel;
  } mem_addr_fields_t;

  // Same 16 bits, either as the host's flat address or as fields
  typedef union packed {
    logic [`MEM_ADDR_W-1:0] flat;
    mem_addr_fields_t       fields;
  } mem_addr_u;

endpackage

// File: hw/mem_bank.sv
`timescale 1ns/1ps
`include "mem_map_macros.svh"

// Single 1K x 16 bank, one port, byte-lane writes
module mem_bank (
  input  logic                        clk,
  input  logic                        we,
  input  logic [`MEM_WORD_IDX_W-1:0]  word,
  input  logic [`MEM_LANES-1:0]       lane,
  input  mem_map_pkg::mem_word_t      di,
  output mem_map_pkg::mem_word_t      q
);

  // Bits per lane and number of words
  localparam int LANE_W = `MEM_DATA_W / `MEM_LANES;
  localparam int DEPTH  = 1 << `MEM_WORD_IDX_W;

  // Storage array, contents undefined after power up
  mem_map_pkg::mem_word_t mem [DEPTH];

  // Word as it stands after this cycle's write
  mem_map_pkg::mem_word_t merged;

  ////////////////////////////////////////////////////////////////////////////
  // Byte-lane merge
  ////////////////////////////////////////////////////////////////////////////

  // Lanes with their enable set take di, the rest keep the stored byte
  always_comb begin
    merged = mem[word];
    for (int l = 0; l < `MEM_LANES; l++) begin
      if (we && lane[l]) begin
        merged[l*LANE_W +: LANE_W] = di[l*LANE_W +: LANE_W];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Array write and registered read
  ////////////////////////////////////////////////////////////////////////////

  // Write-first, q shows the merged word on a write cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[word] <= merged;
    end
    q <= merged;
  end

endmodule

// File: hw/mem_bus_port.sv
`timescale 1ns/1ps
`include "mem_map_macros.svh"

// Host side of the memory
// Four-phase req/ack, address decode and response register
module mem_bus_port (
  input  logic                                     clk,
  input  logic                                     arst_n,
  // Host request
  input  logic                                     req,
  input  logic                                     we,
  input  mem_map_pkg::mem_addr_u                   addr,
  input  mem_map_pkg::mem_word_t                   di,
  input  logic [`MEM_LANES-1:0]                    sel,
  // Host response
  output logic                                     ack,
  output mem_map_pkg::mem_word_t                   q,
  output logic                                     err,
  // Toward the banks
  output logic [`MEM_NUM_BANKS-1:0]                bank_we,
  output logic [`MEM_WORD_IDX_W-1:0]               bank_word,
  output mem_map_pkg::mem_word_t                   bank_di,
  output logic [`MEM_LANES-1:0]                    bank_lane,
  // Read words of all banks, bank 0 in the low bits
  input  logic [`MEM_NUM_BANKS*`MEM_DATA_W-1:0]    bank_q
);

  // Idle, bank cycle, capture of the read word, wait for req low
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESPOND,
    ST_RELEASE
  } state_t;

  state_t state;

  // req as sampled on the previous edge
  logic req_seen;

  // Latched bank index and map check of the request
  logic [`MEM_BANK_IDX_W-1:0] bank_lat;
  logic                       oor_lat;

  // Decode of the live request
  logic                       addr_oor;
  logic [`MEM_NUM_BANKS-1:0]  strobe_nxt;

  // Word that goes back to the host
  mem_map_pkg::mem_word_t     rd_word;

  // Start of an access, request seen while idle
  logic start;

  assign start = (state == ST_IDLE) && req_seen;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Banks 23..31 are not fitted
  assign addr_oor = int'(addr.fields.bank) >= `MEM_NUM_BANKS;

  // One-hot write strobe
  // An unfitted bank index matches no bit, so it writes nothing
  always_comb begin
    strobe_nxt = '0;
    for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
      if (we && (int'(addr.fields.bank) == i)) begin
        strobe_nxt[i] = 1'b1;
      end
    end
  end

  // Read mux, fill word outside the map
  always_comb begin
    rd_word = `MEM_FILL_WORD;
    if (!oor_lat) begin
      rd_word = bank_q[bank_lat*`MEM_DATA_W +: `MEM_DATA_W];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////////////////////

  // Held stable for the bank cycle and the response
  always_ff @(posedge clk) begin
    if (start) begin
      bank_word <= addr.fields.word;
      bank_di   <= di;
      bank_lane <= sel;
      bank_lat  <= addr.fields.bank;
      oor_lat   <= addr_oor;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      req_seen <= 1'b0;
      bank_we  <= '0;
      ack      <= 1'b0;
      err      <= 1'b0;
      q        <= '0;
    end else begin
      req_seen <= req;
      case (state)
        // Edge 1, latch and arm the strobe
        ST_IDLE: begin
          if (req_seen) begin
            bank_we <= strobe_nxt;
            state   <= ST_ACCESS;
          end
        end
        // Edge 2, banks write and read here
        ST_ACCESS: begin
          bank_we <= '0;
          state   <= ST_RESPOND;
        end
        // Edge 3, register the result and answer
        ST_RESPOND: begin
          q     <= rd_word;
          err   <= oor_lat;
          ack   <= 1'b1;
          state <= ST_RELEASE;
        end
        // Hold ack, q and err until the host lets go
        ST_RELEASE: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hw/mem_top.sv
`timescale 1ns/1ps
`include "mem_map_macros.svh"

// Main memory, 23 banks of 1K words behind a req/ack port
// Byte addresses 0000..B7FF
module mem_top (
  input  logic                         clk,
  input  logic                         arst_n,
  // Host request
  input  logic                         req,
  input  logic                         we,
  input  logic [`MEM_ADDR_W-1:0]       addr,
  input  mem_map_pkg::mem_word_t       di,
  input  logic [`MEM_LANES-1:0]        sel,
  // Host response
  output logic                         ack,
  output mem_map_pkg::mem_word_t       q,
  output logic                         err
);

  ////////////////////////////////////////////////////////////////////////////
  // Port to bank wiring
  ////////////////////////////////////////////////////////////////////////////

  // One strobe per bank
  logic [`MEM_NUM_BANKS-1:0]             bank_we;
  // Shared index, data and lanes
  logic [`MEM_WORD_IDX_W-1:0]            bank_word;
  mem_map_pkg::mem_word_t                bank_di;
  logic [`MEM_LANES-1:0]                 bank_lane;
  // All read words, bank n at bits n*16 upward
  logic [`MEM_NUM_BANKS*`MEM_DATA_W-1:0] bank_q;

  // Host port, decode and response
  mem_bus_port port_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .di        (di),
    .sel       (sel),
    .ack       (ack),
    .q         (q),
    .err       (err),
    .bank_we   (bank_we),
    .bank_word (bank_word),
    .bank_di   (bank_di),
    .bank_lane (bank_lane),
    .bank_q    (bank_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bank array
  ////////////////////////////////////////////////////////////////////////////

  // Bank n covers byte addresses n*0800 to n*0800+07FF
  for (genvar n = 0; n < `MEM_NUM_BANKS; n++) begin : bank_g
    mem_bank bank_i (
      .clk  (clk),
      .we   (bank_we[n]),
      .word (bank_word),
      .lane (bank_lane),
      .di   (bank_di),
      .q    (bank_q[n*`MEM_DATA_W +: `MEM_DATA_W])
    );
  end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clock_gen #(
  // Half of the 10 ns period
  parameter int HALF_NS = 5
) (
  output logic clk
);

  // Starts low, first rising edge at HALF_NS
  initial begin
    clk = 1'b0;
    forever begin
      #HALF_NS clk = ~clk;
    end
  end

endmodule

// File: dv/tb_mem_top.sv
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module tb_mem_top;

  // Cycle budget per access and fixed margin for reset and idle checks
  localparam int    CASE_CYCLES  = 20;
  localparam int    SLACK_CYCLES = 50;
  localparam string CASE_FILE    = "dv/mem_cases.txt";

  logic                    clk;
  logic                    arst_n;
  logic                    req;
  logic                    we;
  logic [`MEM_ADDR_W-1:0]  addr;
  logic [`MEM_DATA_W-1:0]  di;
  logic [`MEM_LANES-1:0]   sel;
  logic                    ack;
  logic [`MEM_DATA_W-1:0]  q;
  logic                    err;

  // Case table, one entry per access in the file
  logic [7:0]              op_tab[$];
  logic [`MEM_ADDR_W-1:0]  addr_tab[$];
  logic [`MEM_LANES-1:0]   sel_tab[$];
  logic [`MEM_DATA_W-1:0]  di_tab[$];
  logic [`MEM_DATA_W-1:0]  expq_tab[$];
  logic                    experr_tab[$];

  // Run limit, zero until the case file is loaded
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;
  integer seed;

  tb_clock_gen clk_gen_i (
    .clk (clk)
  );

  mem_top dut_i (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .we     (we),
    .addr   (addr),
    .di     (di),
    .sel    (sel),
    .ack    (ack),
    .q      (q),
    .err    (err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Stop the run on a failure that is not a value mismatch
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  // Compare one observed value with its expected value
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Outputs are sampled and inputs driven 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Lines starting with # are skipped, fields are hex
  task automatic load_cases();
    integer           fd;
    integer           code;
    logic [7:0]       ch;
    logic [31:0]      f_addr;
    logic [31:0]      f_sel;
    logic [31:0]      f_di;
    logic [31:0]      f_q;
    logic [31:0]      f_err;
    logic [8*256-1:0] rest;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the case file dv/mem_cases.txt");
    end else begin
      code = $fscanf(fd, " %c", ch);
      while (code == 1) begin
        if (ch == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, " %h %h %h %h %h", f_addr, f_sel, f_di, f_q, f_err);
          if (code != 5) begin
            abort_run("A line of the case file has missing fields");
          end else if (ch != "W" && ch != "R") begin
            abort_run("The case file holds an operation other than W or R");
          end else begin
            op_tab.push_back(ch);
            addr_tab.push_back(f_addr[`MEM_ADDR_W-1:0]);
            sel_tab.push_back(f_sel[`MEM_LANES-1:0]);
            di_tab.push_back(f_di[`MEM_DATA_W-1:0]);
            expq_tab.push_back(f_q[`MEM_DATA_W-1:0]);
            experr_tab.push_back(f_err[0]);
          end
        end
        code = $fscanf(fd, " %c", ch);
      end
      $fclose(fd);
    end
    if (op_tab.size() == 0) begin
      abort_run("The case file holds no accesses");
    end
    cycle_limit = CASE_CYCLES * op_tab.size() + SLACK_CYCLES;
  endtask

  // One full four-phase access with a random hold after ack
  task automatic run_case(input int idx);
    int hold;
    we   = (op_tab[idx] == "W");
    addr = addr_tab[idx];
    sel  = sel_tab[idx];
    di   = di_tab[idx];
    req  = 1'b1;
    next_cycle();
    while (!ack) begin
      next_cycle();
    end
    check_val($sformatf("q (case %0d)", idx), 32'(q), 32'(expq_tab[idx]));
    check_val($sformatf("err (case %0d)", idx), 32'(err), 32'(experr_tab[idx]));
    // Response must hold while req stays high
    hold = $random(seed) & 3;
    repeat (hold) begin
      next_cycle();
      check_val($sformatf("ack held (case %0d)", idx), 32'(ack), 32'(1));
      check_val($sformatf("q held (case %0d)", idx), 32'(q), 32'(expq_tab[idx]));
      check_val($sformatf("err held (case %0d)", idx), 32'(err), 32'(experr_tab[idx]));
    end
    req = 1'b0;
    we  = 1'b0;
    // ack falls on the first edge that sees req low
    next_cycle();
    check_val($sformatf("ack release (case %0d)", idx), 32'(ack), 32'(0));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run limit
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      abort_run("Timeout: the req/ack handshake hung and the run did not finish");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed   = 32'hc4a7_317f;
    arst_n = 1'b0;
    req    = 1'b0;
    we     = 1'b0;
    addr   = '0;
    di     = '0;
    sel    = '0;
    load_cases();

    // Reset for three cycles
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Quiet bus after reset, no req yet
    repeat (3) begin
      next_cycle();
      check_val("ack after reset", 32'(ack), 32'(0));
      check_val("err after reset", 32'(err), 32'(0));
      check_val("q after reset", 32'(q), 32'(0));
    end

    // Accesses back to back, next req right after ack falls
    for (int i = 0; i < op_tab.size(); i++) begin
      run_case(i);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/mem_map_pkg.sv
hw/mem_bank.sv
hw/mem_bus_port.sv
hw/mem_top.sv
dv/tb_clock_gen.sv
dv/tb_mem_top.sv

// File: Makefile
SIM      := verilator
TOP      := tb_mem_top
FILELIST := sources.f
SFLAGS   := --binary --timing --timescale 1ns/1ps
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := TESTS PASSED

# Sources come from the file list, include directories skipped
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard hw/*.svh)
CASES    := dv/mem_cases.txt
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	./$(BIN) | tee $(LOG)

check: run
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation ok" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/mem_cases.txt
# op addr sel di exp_q exp_err, all fields hex, op is W (write) or R (read)
# A write answers with the merged word, anything outside the map with FFFF
W 0000 3 1234 1234 0
R 0000 3 0000 1234 0
R 0001 3 0000 1234 0
W 0003 3 ABCD ABCD 0
R 0002 0 0000 ABCD 0
R 0003 3 0000 ABCD 0
W 0020 3 5A5A 5A5A 0
W 0020 1 00C3 5AC3 0
R 0020 3 0000 5AC3 0
W 0021 2 7E00 7EC3 0
R 0020 3 0000 7EC3 0
W 0020 0 FFFF 7EC3 0
R 0021 3 0000 7EC3 0
W 0020 1 1122 7E22 0
R 0020 0 0000 7E22 0
W 07FE 3 DEAD DEAD 0
R 07FF 3 0000 DEAD 0
W 0802 3 1111 1111 0
W B002 3 2222 2222 0
W 5802 3 3333 3333 0
R 0002 3 0000 ABCD 0
R 0802 3 0000 1111 0
R B002 3 0000 2222 0
R 5802 3 0000 3333 0
W 0800 3 4444 4444 0
W B000 3 5555 5555 0
W B7FE 3 6666 6666 0
R B7FF 3 0000 6666 0
W B800 3 9999 FFFF 1
W B802 3 9999 FFFF 1
W FFFE 3 9999 FFFF 1
W F800 3 9999 FFFF 1
R B800 3 0000 FFFF 1
R B802 3 0000 FFFF 1
R FFFF 3 0000 FFFF 1
R C3FE 3 0000 FFFF 1
R 0000 3 0000 1234 0
R 0800 3 0000 4444 0
R B000 3 0000 5555 0
R 0002 3 0000 ABCD 0
R B002 3 0000 2222 0
R 07FE 3 0000 DEAD 0
R B7FE 3 0000 6666 0
R B800 3 0000 FFFF 1
R 0802 3 0000 1111 0
W 5803 1 00AA 33AA 0
W 5802 2 BB00 BBAA 0
R 5802 3 0000 BBAA 0
